// File: Makefile
VERILATOR  ?= verilator
TOP        := plotter_tb
FILELIST   := filelist.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -j 0
LOG        := sim.log
SIM_BIN    := obj_dir/V$(TOP)
SOURCES    := $(shell cat $(FILELIST))

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: bench/plotter_sva.sv
`timescale 1ns/1ps

module plotter_sva (
    input logic                     clk,
    input logic                     rst,
    input logic                     req,
    input logic                     ack,
    input logic [plot_pkg::X_W-1:0] x1,
    input logic [plot_pkg::Y_W-1:0] y1,
    input logic [plot_pkg::X_W-1:0] x2,
    input logic [plot_pkg::Y_W-1:0] y2,
    input logic [plot_pkg::X_W-1:0] pixel_x,
    input logic [plot_pkg::Y_W-1:0] pixel_y,
    input logic                     pixel_valid,
    input logic                     pixel_ready
);

    // *************************************************************************
    // Segment handshake.
    // *************************************************************************
    endpoints_stable: assert property (@(posedge clk) disable iff (rst)
        req && $past(req) |-> $stable({x1, y1, x2, y2}))
        else $error("Segment endpoints changed while req was high");

    req_after_ack_low: assert property (@(posedge clk) disable iff (rst)
        $rose(req) |-> !ack)
        else $error("req rose while ack was still high");

    ack_after_req_low: assert property (@(posedge clk) disable iff (rst)
        $fell(ack) |-> !$past(req))
        else $error("ack fell before req was dropped");

    // Pixel stream back-pressure.
    pixel_hold: assert property (@(posedge clk) disable iff (rst)
        pixel_valid && !pixel_ready |=> pixel_valid && $stable({pixel_x, pixel_y}))
        else $error("Pixel outputs changed while stalled");

endmodule

bind line_drawer plotter_sva sva_i (
    .clk         (clk),
    .rst         (rst),
    .req         (seg.req),
    .ack         (seg.ack),
    .x1          (seg.x1),
    .y1          (seg.y1),
    .x2          (seg.x2),
    .y2          (seg.y2),
    .pixel_x     (pixel_x),
    .pixel_y     (pixel_y),
    .pixel_valid (pixel_valid),
    .pixel_ready (pixel_ready)
);

// File: bench/plotter_tb.sv
`timescale 1ns/1ps

module plotter_tb;
    import plot_pkg::*;

    logic                clk;
    logic                rst;
    logic                start;
    logic                busy;
    logic                cfg_we;
    cfg_addr_e           cfg_addr;
    logic [COEF_W-1:0]   cfg_wdata;
    logic [X_W-1:0]      pixel_x;
    logic [Y_W-1:0]      pixel_y;
    logic                pixel_valid;
    logic                pixel_ready;

    logic [X_W-1:0]      exp_x[$];
    logic [Y_W-1:0]      exp_y[$];
    logic [X_W-1:0]      got_x[$];
    logic [Y_W-1:0]      got_y[$];
    int                  model_segs;
    longint              watchdog_units;
    string               test_name;
    int                  test_errors;
    int                  tests_passed;
    int                  tests_failed;

    plotter_top dut_i (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .busy        (busy),
        .cfg_we      (cfg_we),
        .cfg_addr    (cfg_addr),
        .cfg_wdata   (cfg_wdata),
        .pixel_x     (pixel_x),
        .pixel_y     (pixel_y),
        .pixel_valid (pixel_valid),
        .pixel_ready (pixel_ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // *************************************************************************
    // Reference model of the plot and the Bresenham walk.
    // *************************************************************************
    function automatic int build_model(int a, int b, int c, int step);
        int     st;
        int     t;
        int     k;
        longint v;
        longint yl;
        int     xa;
        int     ya;
        int     xb;
        int     yb;
        int     dx;
        int     dy;
        int     sx;
        int     sy;
        int     err;
        int     e2;
        int     pts_x[$];
        int     pts_y[$];
        st = (step == 0) ? 1 : step;               // Zero step is stored as one.
        exp_x.delete();
        exp_y.delete();
        for (t = 0; t * st <= H_PIXELS - 1; t++) begin
            v  = (longint'(a) * t + b) * t + c;
            v  = v >>> FRAC_W;
            yl = longint'(Y_CENTER) - v;
            if (yl < 0)
                yl = 0;
            else if (yl > V_PIXELS - 1)
                yl = V_PIXELS - 1;
            pts_x.push_back(t * st);
            pts_y.push_back(int'(yl));
        end
        model_segs = pts_x.size() - 1;
        for (k = 1; k < pts_x.size(); k++) begin
            xa  = pts_x[k-1];
            ya  = pts_y[k-1];
            xb  = pts_x[k];
            yb  = pts_y[k];
            dx  = (xb > xa) ? xb - xa : xa - xb;
            dy  = (yb > ya) ? yb - ya : ya - yb;
            sx  = (xb >= xa) ? 1 : -1;
            sy  = (yb >= ya) ? 1 : -1;
            err = dx - dy;
            while (1) begin
                exp_x.push_back(X_W'(xa));
                exp_y.push_back(Y_W'(ya));
                if (xa == xb && ya == yb)
                    break;
                e2 = 2 * err;
                if (e2 > -dy) begin
                    err -= dy;
                    xa  += sx;
                end
                if (e2 < dx) begin
                    err += dx;
                    ya  += sy;
                end
            end
        end
        return exp_x.size();
    endfunction

    function automatic longint run_cost(int a, int b, int c, int step);
        int pixels;
        pixels = build_model(a, b, c, step);
        return longint'(pixels) + 64 * model_segs;
    endfunction

    // *************************************************************************
    // Checks and reporting.
    // *************************************************************************
    task automatic compare_coord(input int idx,
                                 input logic [X_W-1:0] ex, input logic [Y_W-1:0] ey,
                                 input logic [X_W-1:0] ax, input logic [Y_W-1:0] ay);
        if (ex !== ax || ey !== ay) begin
            $display("ERROR %s: pixel %0d expected (%0d,%0d) actual (%0d,%0d)",
                     test_name, idx, ex, ey, ax, ay);
            test_errors++;
        end
    endtask

    task automatic compare_count(input string what, input int expected, input int actual);
        if (expected != actual) begin
            $display("ERROR %s: %s expected %0d actual %0d",
                     test_name, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic compare_flag(input string what, input logic expected, input logic actual);
        if (expected !== actual) begin
            $display("ERROR %s: %s expected %b actual %b",
                     test_name, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_stream();
        int n;
        int i;
        compare_count("pixel count", exp_x.size(), got_x.size());
        n = (exp_x.size() < got_x.size()) ? exp_x.size() : got_x.size();
        for (i = 0; i < n; i++)
            compare_coord(i, exp_x[i], exp_y[i], got_x[i], got_y[i]);
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        if (test_errors == 0) begin
            tests_passed++;
            $display("PASS %s (%0d pixels)", test_name, got_x.size());
        end else begin
            tests_failed++;
            $display("FAIL %s (%0d mismatches)", test_name, test_errors);
        end
    endtask

    // *************************************************************************
    // Bus tasks.
    // *************************************************************************
    task automatic write_cfg(input cfg_addr_e addr, input logic [COEF_W-1:0] data);
        @(negedge clk);
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(negedge clk);
        cfg_we    = 1'b0;
    endtask

    task automatic set_config(input int a, input int b, input int c, input int step);
        write_cfg(cfg_coef_a, COEF_W'(a));
        write_cfg(cfg_coef_b, COEF_W'(b));
        write_cfg(cfg_coef_c, COEF_W'(c));
        write_cfg(cfg_step, COEF_W'(step));
    endtask

    // Pulses start, then takes pixels until busy drops.
    task automatic run_plot(input bit random_ready, input int pulse_at);
        bit pulsed;
        pulsed = 1'b0;
        got_x.delete();
        got_y.delete();
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        compare_flag("busy after start", 1'b1, busy);
        while (busy) begin
            pixel_ready = random_ready ? 1'($urandom % 2) : 1'b1;
            start       = 1'b0;
            if (!pulsed && pulse_at >= 0 && got_x.size() == pulse_at) begin
                start  = 1'b1;                     // Must be ignored while busy.
                pulsed = 1'b1;
            end
            if (pixel_valid && pixel_ready) begin
                got_x.push_back(pixel_x);
                got_y.push_back(pixel_y);
            end
            @(negedge clk);
        end
        start       = 1'b0;
        pixel_ready = 1'b1;
    endtask

    // *************************************************************************
    // Directed tests.
    // *************************************************************************
    task automatic reset_default_plot();
        int off_row;
        int i;
        begin_test("reset_default");
        compare_flag("busy", 1'b0, busy);
        compare_flag("pixel_valid", 1'b0, pixel_valid);
        void'(build_model(0, 0, 0, STEP_RESET));
        run_plot(1'b0, -1);
        check_stream();
        compare_count("pixels", (H_PIXELS - 1) / STEP_RESET * (STEP_RESET + 1), got_x.size());
        off_row = 0;
        for (i = 0; i < got_y.size(); i++)
            if (got_y[i] != Y_W'(Y_CENTER))
                off_row++;
        compare_count("pixels off the centre row", 0, off_row);
        end_test();
    endtask

    task automatic linear_plot();
        begin_test("linear");
        set_config(0, 384, 0, 16);                 // b = 1.5.
        void'(build_model(0, 384, 0, 16));
        run_plot(1'b0, -1);
        check_stream();
        end_test();
    endtask

    task automatic clipped_quadratic_plot();
        bit row_seen [V_PIXELS];
        int covered;
        int i;
        begin_test("quadratic_clip");
        set_config(512, -25600, 0, 8);             // a = 2, b = -100.
        void'(build_model(512, -25600, 0, 8));
        run_plot(1'b0, -1);
        check_stream();
        for (i = 0; i < V_PIXELS; i++)
            row_seen[i] = 1'b0;
        for (i = 0; i < got_y.size(); i++)
            if (got_y[i] < V_PIXELS)
                row_seen[got_y[i]] = 1'b1;
        covered = 0;
        for (i = 0; i < V_PIXELS; i++)
            if (row_seen[i])
                covered++;
        compare_count("rows covered", V_PIXELS, covered);
        end_test();
    endtask

    task automatic back_pressure_plot();
        begin_test("back_pressure");
        set_config(0, -576, 25600, 4);             // b = -2.25, c = 100.
        void'(build_model(0, -576, 25600, 4));
        run_plot(1'b0, -1);
        check_stream();
        run_plot(1'b1, -1);
        check_stream();
        end_test();
    endtask

    task automatic zero_step_plot();
        begin_test("zero_step");
        set_config(0, 128, 0, 0);                  // b = 0.5.
        void'(build_model(0, 128, 0, 0));
        run_plot(1'b0, 100);
        check_stream();
        compare_count("pixels", 2 * (H_PIXELS - 1), got_x.size());
        repeat (5) @(negedge clk);
        compare_flag("busy after end", 1'b0, busy);
        end_test();
    endtask

    initial begin
        void'($urandom(45));
        rst          = 1'b1;
        start        = 1'b0;
        cfg_we       = 1'b0;
        cfg_addr     = cfg_coef_a;
        cfg_wdata    = '0;
        pixel_ready  = 1'b1;
        tests_passed = 0;
        tests_failed = 0;

        watchdog_units = run_cost(0, 0, 0, STEP_RESET);
        watchdog_units += run_cost(0, 384, 0, 16);
        watchdog_units += run_cost(512, -25600, 0, 8);
        watchdog_units += 2 * run_cost(0, -576, 25600, 4);
        watchdog_units += run_cost(0, 128, 0, 0);

        fork
            begin
                #(longint'(4 * 8) * (watchdog_units + 1000));
                $display("Timeout: the tests did not finish in the expected time");
                $display("SIMULATION FAILED");
                $finish;
            end
        join_none

        repeat (4) @(negedge clk);
        rst = 1'b0;

        reset_default_plot();
        linear_plot();
        clipped_quadratic_plot();
        back_pressure_plot();
        zero_step_plot();

        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// File: filelist.f
rtl/plot_pkg.sv
rtl/plot_ifs.sv
rtl/plot_config.sv
rtl/poly_eval.sv
rtl/plot_controller.sv
rtl/line_drawer.sv
rtl/plotter_top.sv
bench/plotter_sva.sv
bench/plotter_tb.sv

// File: rtl/line_drawer.sv
`timescale 1ns/1ps

module line_drawer (
    input  logic                     clk,
    input  logic                     rst,
    segment_if.slave                 seg,
    output logic [plot_pkg::X_W-1:0] pixel_x,
    output logic [plot_pkg::Y_W-1:0] pixel_y,
    output logic                     pixel_valid,
    input  logic                     pixel_ready
);
    import plot_pkg::*;

    draw_state_e             state_q;
    logic [X_W-1:0]          cur_x_q;
    logic [Y_W-1:0]          cur_y_q;
    logic [X_W-1:0]          end_x_q;
    logic [Y_W-1:0]          end_y_q;
    logic                    sx_neg_q;
    logic                    sy_neg_q;
    logic signed [ERR_W-1:0] dx_q;
    logic signed [ERR_W-1:0] dy_q;
    logic signed [ERR_W-1:0] err_q;
    logic signed [ERR_W-1:0] dx_raw;
    logic signed [ERR_W-1:0] dy_raw;
    logic signed [ERR_W-1:0] dx_abs;
    logic signed [ERR_W-1:0] dy_abs;
    logic signed [ERR_W-1:0] e2;
    logic                    step_x;
    logic                    step_y;
    logic                    fire;
    logic                    at_end;

    // *************************************************************************
    // Segment setup from the requested endpoints.
    // *************************************************************************
    assign dx_raw = $signed(ERR_W'(seg.x2)) - $signed(ERR_W'(seg.x1));
    assign dy_raw = $signed(ERR_W'(seg.y2)) - $signed(ERR_W'(seg.y1));
    assign dx_abs = (dx_raw < 0) ? -dx_raw : dx_raw;
    assign dy_abs = (dy_raw < 0) ? -dy_raw : dy_raw;

    // Bresenham decisions.
    assign e2     = err_q <<< 1;
    assign step_x = e2 > -dy_q;
    assign step_y = e2 < dx_q;

    assign fire   = pixel_valid && pixel_ready;
    assign at_end = (cur_x_q == end_x_q) && (cur_y_q == end_y_q);

    assign pixel_valid = state_q == draw_run;
    assign pixel_x     = cur_x_q;
    assign pixel_y     = cur_y_q;
    assign seg.ack     = state_q == draw_done;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= draw_idle;
        end else begin
            case (state_q)
                draw_idle: begin
                    if (seg.req) begin
                        cur_x_q  <= seg.x1;
                        cur_y_q  <= seg.y1;
                        end_x_q  <= seg.x2;
                        end_y_q  <= seg.y2;
                        sx_neg_q <= dx_raw < 0;
                        sy_neg_q <= dy_raw < 0;
                        dx_q     <= dx_abs;
                        dy_q     <= dy_abs;
                        err_q    <= dx_abs - dy_abs;
                        state_q  <= draw_run;
                    end
                end
                draw_run: begin
                    if (fire) begin
                        if (at_end) begin
                            state_q <= draw_done;     // Last pixel taken.
                        end else begin
                            if (step_x)
                                cur_x_q <= sx_neg_q ? cur_x_q - 1'b1 : cur_x_q + 1'b1;
                            if (step_y)
                                cur_y_q <= sy_neg_q ? cur_y_q - 1'b1 : cur_y_q + 1'b1;
                            err_q <= err_q - (step_x ? dy_q : '0) + (step_y ? dx_q : '0);
                        end
                    end
                end
                draw_done: begin
                    if (!seg.req)
                        state_q <= draw_idle;
                end
                default: state_q <= draw_idle;
            endcase
        end
    end

endmodule

// File: rtl/plot_config.sv
`timescale 1ns/1ps

module plot_config (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        we,
    input  plot_pkg::cfg_addr_e         addr,
    input  logic [plot_pkg::COEF_W-1:0] wdata,
    plot_cfg_if.src                     cfg
);
    import plot_pkg::*;

    logic signed [COEF_W-1:0] coef_a_q;
    logic signed [COEF_W-1:0] coef_b_q;
    logic signed [COEF_W-1:0] coef_c_q;
    logic        [X_W-1:0]    step_q;
    logic        [X_W-1:0]    step_wr;

    // A zero step would never advance x.
    assign step_wr = (wdata[X_W-1:0] == '0) ? X_W'(1) : wdata[X_W-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            coef_a_q <= '0;
            coef_b_q <= '0;
            coef_c_q <= '0;
            step_q   <= X_W'(STEP_RESET);
        end else if (we) begin
            case (addr)
                cfg_coef_a: coef_a_q <= wdata;
                cfg_coef_b: coef_b_q <= wdata;
                cfg_coef_c: coef_c_q <= wdata;
                cfg_step:   step_q   <= step_wr;
            endcase
        end
    end

    assign cfg.coef_a = coef_a_q;
    assign cfg.coef_b = coef_b_q;
    assign cfg.coef_c = coef_c_q;
    assign cfg.step   = step_q;

endmodule

// File: rtl/plot_controller.sv
`timescale 1ns/1ps

module plot_controller (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,
    output logic                     busy,
    plot_cfg_if.dst                  cfg,
    output logic [plot_pkg::X_W-1:0] eval_t,
    output logic                     eval_start,
    input  logic [plot_pkg::Y_W-1:0] eval_y,
    input  logic                     eval_valid,
    segment_if.master                seg
);
    import plot_pkg::*;

    ctrl_state_e    state_q;
    logic [X_W-1:0] t_q;
    logic [X_W-1:0] x_q;
    logic [X_W-1:0] prev_x_q;
    logic [Y_W-1:0] prev_y_q;
    logic [Y_W-1:0] cur_y_q;
    logic [X_W:0]   x_next;
    logic           last_point;

    // One extra bit so the step past the right edge is seen.
    assign x_next     = {1'b0, x_q} + {1'b0, cfg.step};
    assign last_point = x_next > (X_W + 1)'(H_PIXELS - 1);

    assign busy       = state_q != ctrl_idle;
    assign eval_start = state_q == ctrl_eval;
    assign eval_t     = t_q;

    // *************************************************************************
    // Segment endpoints stay in registers for the whole handshake.
    // *************************************************************************
    assign seg.req = state_q == ctrl_req;
    assign seg.x1  = prev_x_q;
    assign seg.y1  = prev_y_q;
    assign seg.x2  = x_q;
    assign seg.y2  = cur_y_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ctrl_idle;
            t_q     <= '0;
            x_q     <= '0;
        end else begin
            case (state_q)
                ctrl_idle: begin
                    t_q <= '0;
                    x_q <= '0;
                    if (start)
                        state_q <= ctrl_eval;
                end
                ctrl_eval: begin
                    state_q <= ctrl_wait_eval;
                end
                ctrl_wait_eval: begin
                    if (eval_valid) begin
                        if (t_q == '0) begin          // First point only seeds.
                            prev_x_q <= x_q;
                            prev_y_q <= eval_y;
                            if (last_point) begin
                                state_q <= ctrl_idle;
                            end else begin
                                t_q     <= t_q + 1'b1;
                                x_q     <= x_next[X_W-1:0];
                                state_q <= ctrl_eval;
                            end
                        end else begin
                            cur_y_q <= eval_y;
                            state_q <= ctrl_req;
                        end
                    end
                end
                ctrl_req: begin
                    if (seg.ack)
                        state_q <= ctrl_wait_ack;     // Drops req.
                end
                ctrl_wait_ack: begin
                    if (!seg.ack) begin
                        prev_x_q <= x_q;
                        prev_y_q <= cur_y_q;
                        if (last_point) begin
                            state_q <= ctrl_idle;
                        end else begin
                            t_q     <= t_q + 1'b1;
                            x_q     <= x_next[X_W-1:0];
                            state_q <= ctrl_eval;
                        end
                    end
                end
                default: state_q <= ctrl_idle;
            endcase
        end
    end

endmodule

// File: rtl/plot_ifs.sv
`timescale 1ns/1ps

interface plot_cfg_if;
    import plot_pkg::*;

    logic signed [COEF_W-1:0] coef_a;
    logic signed [COEF_W-1:0] coef_b;
    logic signed [COEF_W-1:0] coef_c;
    logic        [X_W-1:0]    step;

    modport src (output coef_a, coef_b, coef_c, step);
    modport dst (input  coef_a, coef_b, coef_c, step);
endinterface

interface segment_if;
    import plot_pkg::*;

    logic [X_W-1:0] x1;
    logic [Y_W-1:0] y1;
    logic [X_W-1:0] x2;
    logic [Y_W-1:0] y2;
    logic           req;
    logic           ack;

    modport master (output x1, y1, x2, y2, req, input  ack);
    modport slave  (input  x1, y1, x2, y2, req, output ack);
endinterface

// File: rtl/plot_pkg.sv
package plot_pkg;

    // *************************************************************************
    // Screen geometry.
    // *************************************************************************
    localparam int H_PIXELS = 640;
    localparam int V_PIXELS = 480;
    localparam int Y_CENTER = V_PIXELS / 2;  // Row for a function value of zero.

    localparam int X_W = 10;                 // x and t.
    localparam int Y_W = 9;

    // *************************************************************************
    // Number formats.
    // *************************************************************************
    localparam int COEF_W = 16;              // Signed 8.8.
    localparam int FRAC_W = 8;

    // Horner stage widths, sized for the worst case t of 1023.
    localparam int EVAL1_W = COEF_W + X_W + 1;
    localparam int EVAL2_W = EVAL1_W + X_W + 1;

    localparam int ERR_W = X_W + 2;          // Holds 2*err for the widest span.

    localparam int STEP_RESET = 8;

    // *************************************************************************
    // Encodings.
    // *************************************************************************
    typedef enum logic [1:0] {
        cfg_coef_a = 2'd0,
        cfg_coef_b = 2'd1,
        cfg_coef_c = 2'd2,
        cfg_step   = 2'd3
    } cfg_addr_e;

    typedef enum logic [2:0] {
        ctrl_idle,
        ctrl_eval,
        ctrl_wait_eval,
        ctrl_req,
        ctrl_wait_ack
    } ctrl_state_e;

    typedef enum logic [1:0] {
        draw_idle,
        draw_run,
        draw_done
    } draw_state_e;

endpackage

// File: rtl/plotter_top.sv
`timescale 1ns/1ps

module plotter_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        start,
    output logic                        busy,
    input  logic                        cfg_we,
    input  plot_pkg::cfg_addr_e         cfg_addr,
    input  logic [plot_pkg::COEF_W-1:0] cfg_wdata,
    output logic [plot_pkg::X_W-1:0]    pixel_x,
    output logic [plot_pkg::Y_W-1:0]    pixel_y,
    output logic                        pixel_valid,
    input  logic                        pixel_ready
);
    import plot_pkg::*;

    logic [X_W-1:0] eval_t;
    logic           eval_start;
    logic [Y_W-1:0] eval_y;
    logic           eval_valid;

    plot_cfg_if cfg_bus ();
    segment_if  seg_bus ();

    plot_config config_i (
        .clk   (clk),
        .rst   (rst),
        .we    (cfg_we),
        .addr  (cfg_addr),
        .wdata (cfg_wdata),
        .cfg   (cfg_bus.src)
    );

    poly_eval eval_i (
        .clk   (clk),
        .rst   (rst),
        .cfg   (cfg_bus.dst),
        .t     (eval_t),
        .start (eval_start),
        .y     (eval_y),
        .valid (eval_valid)
    );

    plot_controller ctrl_i (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .busy       (busy),
        .cfg        (cfg_bus.dst),
        .eval_t     (eval_t),
        .eval_start (eval_start),
        .eval_y     (eval_y),
        .eval_valid (eval_valid),
        .seg        (seg_bus.master)
    );

    line_drawer drawer_i (
        .clk         (clk),
        .rst         (rst),
        .seg         (seg_bus.slave),
        .pixel_x     (pixel_x),
        .pixel_y     (pixel_y),
        .pixel_valid (pixel_valid),
        .pixel_ready (pixel_ready)
    );

endmodule

// File: rtl/poly_eval.sv
`timescale 1ns/1ps

module poly_eval (
    input  logic                     clk,
    input  logic                     rst,
    plot_cfg_if.dst                  cfg,
    input  logic [plot_pkg::X_W-1:0] t,
    input  logic                     start,
    output logic [plot_pkg::Y_W-1:0] y,
    output logic                     valid
);
    import plot_pkg::*;

    logic signed [X_W:0]       t_s;
    logic signed [X_W:0]       t1_s;
    logic signed [EVAL1_W-1:0] s1_d;
    logic signed [EVAL1_W-1:0] s1_q;
    logic        [X_W-1:0]     t1_q;
    logic                      v1_q;
    logic signed [EVAL2_W-1:0] s2;
    logic signed [EVAL2_W-1:0] v;
    logic signed [EVAL2_W-1:0] diff;
    logic        [Y_W-1:0]     y_clamp;
    logic        [Y_W-1:0]     y_q;
    logic                      valid_q;

    // Stage one: a*t + b.
    assign t_s  = $signed({1'b0, t});
    assign s1_d = $signed(cfg.coef_a) * t_s + $signed(cfg.coef_b);

    // Stage two: (a*t + b)*t + c, then to screen rows.
    assign t1_s = $signed({1'b0, t1_q});
    assign s2   = s1_q * t1_s + $signed(cfg.coef_c);
    assign v    = s2 >>> FRAC_W;                     // Drop the fraction.
    assign diff = EVAL2_W'(Y_CENTER) - v;            // Screen y grows downward.

    always_comb begin
        if (diff < 0)
            y_clamp = '0;
        else if (diff > EVAL2_W'(V_PIXELS - 1))
            y_clamp = Y_W'(V_PIXELS - 1);
        else
            y_clamp = diff[Y_W-1:0];
    end

    always_ff @(posedge clk) begin
        s1_q <= s1_d;
        t1_q <= t;
        y_q  <= y_clamp;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            v1_q    <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            v1_q    <= start;
            valid_q <= v1_q;
        end
    end

    assign y     = y_q;
    assign valid = valid_q;

endmodule
